// File: Makefile
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f src.f --top-module tb_pkt_proc

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f src.f \
		--top-module tb_pkt_proc -o tb_pkt_proc
	./obj_dir/tb_pkt_proc | tee $(LOG)
	@! grep -q "TEST FAILED" $(LOG)
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: pkt_arbiter.sv
module pkt_arbiter (
    input  logic                     core_clk,
    input  logic                     rst_n,
    input  proc_pkg::timestamp_t     timestamp,
    input  stream_pkg::stream_beat_t in_beat [proc_pkg::NUM_PORTS],
    input  logic                     in_valid [proc_pkg::NUM_PORTS],
    output logic                     in_ready [proc_pkg::NUM_PORTS],
    output stream_pkg::stream_beat_t out_beat,
    output logic                     out_valid,
    input  logic                     out_ready
);
    import stream_pkg::*;
    import proc_pkg::*;

    // port of the last grant, which resets to 1 so that port 0 goes first
    port_t        grant;
    logic         pkt_open;
    timestamp_t   ts_hold;

    port_t        sel;
    logic         slot_free;
    logic         accept;
    stream_beat_t sel_beat;

    // ----------------------------------------
    // packet-level round robin
    // ----------------------------------------
    // stay locked while a packet is open and otherwise prefer the other port
    always_comb begin
        if (pkt_open) begin
            sel = grant;
        end else if (in_valid[~grant]) begin
            sel = ~grant;
        end else begin
            sel = grant;
        end
    end

    assign slot_free = !out_valid || out_ready;
    assign accept    = in_valid[sel] && slot_free;

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            in_ready[i] = slot_free && (sel == port_t'(i));
        end
    end

    // ----------------------------------------
    // timestamp and port tagging
    // ----------------------------------------
    // the first beat samples the live timestamp and later beats reuse it
    always_comb begin
        sel_beat = in_beat[sel];
        sel_beat.meta.timestamp = pkt_open ? ts_hold : timestamp;
        sel_beat.meta.pid[PID_PORT_BIT] = sel;
    end

    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            grant     <= 1'b1;
            pkt_open  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (accept) begin
                grant    <= sel;
                pkt_open <= !sel_beat.last;
            end
            if (slot_free) begin
                out_valid <= accept;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (accept) begin
            out_beat <= sel_beat;
            if (!pkt_open) begin
                ts_hold <= timestamp;
            end
        end
    end

    // the grant holds from a packet's first beat through its last beat
    property p_grant_locked;
        @(posedge core_clk) disable iff (!rst_n)
        pkt_open |=> (grant == $past(grant));
    endproperty

    a_grant_locked: assert property (p_grant_locked);

endmodule

// File: pkt_drop_filter.sv
module pkt_drop_filter (
    input  logic                     core_clk,
    input  logic                     rst_n,
    input  logic                     drop_loop,
    input  stream_pkg::stream_beat_t in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    output stream_pkg::stream_beat_t out_beat,
    output logic                     out_valid,
    input  logic                     out_ready
);

    // next accepted beat starts a packet
    logic first;
    // decision taken on the first beat, kept to the last
    logic drop_hold;

    logic zero_len;
    logic loop_hit;
    logic drop_now;
    logic slot_free;
    logic accept;

    // ----------------------------------------
    // drop decision
    // ----------------------------------------
    assign zero_len = in_beat.last && (in_beat.keep == '0);
    assign loop_hit = drop_loop && (in_beat.tdest == in_beat.tid);
    assign drop_now = first ? (zero_len || loop_hit) : drop_hold;

    // dropped beats are swallowed without needing the output slot
    assign slot_free = !out_valid || out_ready;
    assign in_ready  = slot_free || drop_now;
    assign accept    = in_valid && in_ready;

    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            first     <= 1'b1;
            drop_hold <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (accept) begin
                first     <= in_beat.last;
                drop_hold <= drop_now;
            end
            if (accept && !drop_now) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (accept && !drop_now) begin
            out_beat <= in_beat;
        end
    end

endmodule

// File: pkt_proc_top.sv
module pkt_proc_top (
    input  logic                     core_clk,
    input  logic                     rst_n,
    input  stream_pkg::stream_beat_t in_beat [proc_pkg::NUM_PORTS],
    input  logic                     in_valid [proc_pkg::NUM_PORTS],
    output logic                     in_ready [proc_pkg::NUM_PORTS],
    output stream_pkg::stream_beat_t out_beat [proc_pkg::NUM_PORTS],
    output logic                     out_valid [proc_pkg::NUM_PORTS],
    input  logic                     out_ready [proc_pkg::NUM_PORTS],
    input  proc_pkg::proc_cfg_t      cfg,
    input  proc_pkg::timestamp_t     timestamp
);
    import stream_pkg::*;
    import proc_pkg::*;

    // merged path
    stream_beat_t arb_beat;
    logic         arb_valid;
    logic         arb_ready;

    // per-port egress chain
    stream_beat_t proc_beat  [NUM_PORTS];
    logic         proc_valid [NUM_PORTS];
    logic         proc_ready [NUM_PORTS];
    stream_beat_t drop_beat  [NUM_PORTS];
    logic         drop_valid [NUM_PORTS];
    logic         drop_ready [NUM_PORTS];

    // ----------------------------------------
    // shared processing path
    // ----------------------------------------
    pkt_arbiter i_arbiter (
        .core_clk  (core_clk),
        .rst_n     (rst_n),
        .timestamp (timestamp),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (arb_beat),
        .out_valid (arb_valid),
        .out_ready (arb_ready)
    );

    proc_stage i_proc_stage (
        .core_clk  (core_clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .in_beat   (arb_beat),
        .in_valid  (arb_valid),
        .in_ready  (arb_ready),
        .out_beat  (proc_beat),
        .out_valid (proc_valid),
        .out_ready (proc_ready)
    );

    // ----------------------------------------
    // drop then truncate on each egress port
    // ----------------------------------------
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        pkt_drop_filter i_drop (
            .core_clk  (core_clk),
            .rst_n     (rst_n),
            .drop_loop (cfg.drop_loop),
            .in_beat   (proc_beat[i]),
            .in_valid  (proc_valid[i]),
            .in_ready  (proc_ready[i]),
            .out_beat  (drop_beat[i]),
            .out_valid (drop_valid[i]),
            .out_ready (drop_ready[i])
        );

        pkt_truncator i_trunc (
            .core_clk  (core_clk),
            .rst_n     (rst_n),
            .in_beat   (drop_beat[i]),
            .in_valid  (drop_valid[i]),
            .in_ready  (drop_ready[i]),
            .out_beat  (out_beat[i]),
            .out_valid (out_valid[i]),
            .out_ready (out_ready[i])
        );
    end

endmodule

// File: pkt_truncator.sv
module pkt_truncator (
    input  logic                     core_clk,
    input  logic                     rst_n,
    input  stream_pkg::stream_beat_t in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    output stream_pkg::stream_beat_t out_beat,
    output logic                     out_valid,
    input  logic                     out_ready
);
    import stream_pkg::*;
    import proc_pkg::*;

    // bytes already passed in the current packet
    logic [LEN_BITS-1:0]      byte_cnt;
    logic                     first;
    // set after the cut until the original last beat
    logic                     discard;

    logic [KEEP_CNT_BITS-1:0] beat_bytes;
    logic [LEN_BITS:0]        total;
    logic [LEN_BITS-1:0]      remain;
    logic                     cut;
    stream_beat_t             beat_cut;
    logic                     slot_free;
    logic                     accept;

    // ----------------------------------------
    // byte accounting
    // ----------------------------------------
    always_comb begin
        beat_bytes = '0;
        for (int b = 0; b < DATA_BYTES; b++) begin
            beat_bytes = beat_bytes + KEEP_CNT_BITS'(in_beat.keep[b]);
        end
    end

    assign total  = {1'b0, byte_cnt} + (LEN_BITS + 1)'(beat_bytes);
    assign remain = in_beat.meta.trunc_length - byte_cnt;
    assign cut    = in_beat.meta.trunc_enable &&
                    (total >= {1'b0, in_beat.meta.trunc_length});

    // ----------------------------------------
    // trim the cut beat
    // ----------------------------------------
    // remain is at most DATA_BYTES here so keep stays contiguous
    always_comb begin
        beat_cut = in_beat;
        if (cut) begin
            for (int b = 0; b < DATA_BYTES; b++) begin
                beat_cut.keep[b] = in_beat.keep[b] && (LEN_BITS'(b) < remain);
            end
            beat_cut.last = 1'b1;
        end
    end

    assign slot_free = !out_valid || out_ready;
    assign in_ready  = discard || slot_free;
    assign accept    = in_valid && in_ready;

    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            byte_cnt  <= '0;
            first     <= 1'b1;
            discard   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (accept) begin
                first   <= in_beat.last;
                discard <= (discard || cut) && !in_beat.last;
                if (discard || cut || in_beat.last) begin
                    byte_cnt <= '0;
                end else begin
                    byte_cnt <= total[LEN_BITS-1:0];
                end
            end
            if (accept && !discard) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (accept && !discard) begin
            out_beat <= beat_cut;
        end
    end

    // a zero cut length would leave an empty packet behind
    a_trunc_len: assert property (@(posedge core_clk) disable iff (!rst_n)
        (accept && first && in_beat.meta.trunc_enable) |->
            (in_beat.meta.trunc_length != '0));

endmodule

// File: proc_pkg.sv
package proc_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int NUM_PORTS = 2;
    localparam int TS_BITS   = 48;
    localparam int PID_BITS  = 10;
    localparam int LEN_BITS  = 16;

    // the top pid bit carries the port a packet returns to
    localparam int PID_PORT_BIT = PID_BITS - 1;

    typedef logic [TS_BITS-1:0] timestamp_t;

    // ----------------------------------------
    // per-packet metadata
    // ----------------------------------------
    // repeated on every beat of a packet
    typedef struct packed {
        timestamp_t          timestamp;
        logic [PID_BITS-1:0] pid;
        logic                trunc_enable;
        logic [LEN_BITS-1:0] trunc_length;
    } pkt_meta_t;

    // ----------------------------------------
    // static configuration
    // ----------------------------------------
    typedef struct packed {
        // discard packets whose tdest equals tid
        logic                drop_loop;
        // stall the shared processing path
        logic                pause;
        // take trunc settings from here instead of the packet
        logic                trunc_override;
        logic                trunc_enable;
        logic [LEN_BITS-1:0] trunc_length;
    } proc_cfg_t;

endpackage

// File: proc_stage.sv
module proc_stage (
    input  logic                     core_clk,
    input  logic                     rst_n,
    input  proc_pkg::proc_cfg_t      cfg,
    input  stream_pkg::stream_beat_t in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    output stream_pkg::stream_beat_t out_beat [proc_pkg::NUM_PORTS],
    output logic                     out_valid [proc_pkg::NUM_PORTS],
    input  logic                     out_ready [proc_pkg::NUM_PORTS]
);
    import stream_pkg::*;
    import proc_pkg::*;

    stream_beat_t beat_q;
    port_t        lane_q;
    logic         valid_q;

    stream_beat_t beat_mod;
    logic         drain;
    logic         accept;

    // ----------------------------------------
    // pause gate
    // ----------------------------------------
    assign drain    = valid_q && out_ready[lane_q];
    assign in_ready = !cfg.pause && (!valid_q || drain);
    assign accept   = in_valid && in_ready;

    // ----------------------------------------
    // metadata override
    // ----------------------------------------
    always_comb begin
        beat_mod = in_beat;
        if (cfg.trunc_override) begin
            beat_mod.meta.trunc_enable = cfg.trunc_enable;
            beat_mod.meta.trunc_length = cfg.trunc_length;
        end
        // return port is consumed here
        beat_mod.meta.pid[PID_PORT_BIT] = 1'b0;
    end

    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (drain) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge core_clk) begin
        if (accept) begin
            beat_q <= beat_mod;
            lane_q <= in_beat.meta.pid[PID_PORT_BIT];
        end
    end

    // ----------------------------------------
    // return-port demux
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            out_beat[i]  = beat_q;
            out_valid[i] = valid_q && (lane_q == port_t'(i));
        end
    end

    // an accepted beat shows up on the lane its pid names and on no other
    a_one_lane: assert property (@(posedge core_clk) disable iff (!rst_n)
        accept |=> ((out_valid[1] == $past(in_beat.meta.pid[PID_PORT_BIT])) &&
                    (out_valid[0] == !$past(in_beat.meta.pid[PID_PORT_BIT]))));

endmodule

// File: src.f
proc_pkg.sv
stream_pkg.sv
pkt_arbiter.sv
proc_stage.sv
pkt_drop_filter.sv
pkt_truncator.sv
pkt_proc_top.sv
tb_pkt_proc.sv

// File: stream_pkg.sv
package stream_pkg;

    import proc_pkg::*;

    // ----------------------------------------
    // beat geometry
    // ----------------------------------------
    localparam int DATA_BYTES = 8;
    localparam int DATA_BITS  = DATA_BYTES * 8;

    // enough bits to count 0..DATA_BYTES valid bytes
    localparam int KEEP_CNT_BITS = $clog2(DATA_BYTES + 1);

    // ingress or egress port number
    typedef logic port_t;

    // ----------------------------------------
    // one stream beat
    // ----------------------------------------
    typedef struct packed {
        logic [DATA_BITS-1:0]  data;
        // contiguous from byte 0
        logic [DATA_BYTES-1:0] keep;
        logic                  last;
        port_t                 tid;
        port_t                 tdest;
        pkt_meta_t             meta;
    } stream_beat_t;

endpackage

// File: tb_pkt_proc.sv
module tb_pkt_proc;
    timeunit 1ns;
    timeprecision 1ps;

    import stream_pkg::*;
    import proc_pkg::*;

    localparam int WAIT_LIMIT = 200;
    localparam int NUM_ROWS   = 14;

    // one packet of stimulus in a phase whose packets share one cfg
    typedef struct packed {
        logic [1:0]          phase;
        port_t               port;
        port_t               tdest;
        logic [7:0]          len;
        logic                m_en;
        logic [LEN_BITS-1:0] m_len;
    } pkt_row_t;

    // drop_loop, pause, trunc_override, trunc_enable, trunc_length
    localparam proc_cfg_t PHASE_CFG [4] = '{
        '{1'b0, 1'b0, 1'b0, 1'b0, 16'd0},
        '{1'b1, 1'b0, 1'b0, 1'b0, 16'd0},
        '{1'b0, 1'b0, 1'b1, 1'b1, 16'd10},
        '{1'b0, 1'b1, 1'b0, 1'b0, 16'd0}
    };

    localparam pkt_row_t ROWS [NUM_ROWS] = '{
        '{2'd0, 1'b0, 1'b1, 8'd20, 1'b0, 16'd0},
        '{2'd0, 1'b1, 1'b0, 8'd13, 1'b0, 16'd0},
        // zero-length packet with another one right behind it
        '{2'd0, 1'b0, 1'b0, 8'd0,  1'b0, 16'd0},
        '{2'd0, 1'b0, 1'b1, 8'd9,  1'b1, 16'd5},
        '{2'd0, 1'b1, 1'b1, 8'd24, 1'b1, 16'd30},
        '{2'd0, 1'b1, 1'b0, 8'd16, 1'b1, 16'd8},
        '{2'd1, 1'b0, 1'b0, 8'd12, 1'b0, 16'd0},
        '{2'd1, 1'b0, 1'b1, 8'd7,  1'b0, 16'd0},
        '{2'd1, 1'b1, 1'b1, 8'd30, 1'b0, 16'd0},
        '{2'd2, 1'b0, 1'b1, 8'd20, 1'b0, 16'd0},
        '{2'd2, 1'b1, 1'b0, 8'd6,  1'b1, 16'd3},
        // both ports queue up behind the pause
        '{2'd3, 1'b0, 1'b1, 8'd17, 1'b0, 16'd0},
        '{2'd3, 1'b1, 1'b0, 8'd11, 1'b0, 16'd0},
        '{2'd3, 1'b0, 1'b1, 8'd5,  1'b0, 16'd0}
    };

    logic         core_clk;
    logic         rst_n;
    stream_beat_t in_beat   [NUM_PORTS];
    logic         in_valid  [NUM_PORTS];
    logic         in_ready  [NUM_PORTS];
    stream_beat_t out_beat  [NUM_PORTS];
    logic         out_valid [NUM_PORTS];
    logic         out_ready [NUM_PORTS];
    proc_cfg_t    cfg;
    timestamp_t   timestamp;

    stream_beat_t exp_q [NUM_PORTS][$];
    int           errors;
    int           checked;
    bit           timed_out;

    pkt_proc_top i_dut (.*);

    always #5 core_clk = ~core_clk;

    // ----------------------------------------
    // free-running timestamp and random egress stalls
    // ----------------------------------------
    always @(negedge core_clk) begin
        timestamp = timestamp + 1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            out_ready[p] = ($urandom_range(3) != 0);
        end
    end

    function automatic logic [DATA_BYTES-1:0] keep_mask(input int n);
        return DATA_BYTES'((1 << n) - 1);
    endfunction

    task automatic check_value(input int p, input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            $display("error out_beat[%0d].%s: got %h, expected %h", p, name, got, want);
            errors++;
        end
    endtask

    task automatic check_beat(input int p);
        stream_beat_t want;
        if (exp_q[p].size() == 0) begin
            $display("port %0d delivered a beat that no packet should produce", p);
            errors++;
        end else begin
            want = exp_q[p].pop_front();
            checked++;
            check_value(p, "data", out_beat[p].data, want.data);
            check_value(p, "keep", 64'(out_beat[p].keep), 64'(want.keep));
            check_value(p, "last", 64'(out_beat[p].last), 64'(want.last));
            check_value(p, "tid", 64'(out_beat[p].tid), 64'(want.tid));
            check_value(p, "tdest", 64'(out_beat[p].tdest), 64'(want.tdest));
            check_value(p, "meta.timestamp", 64'(out_beat[p].meta.timestamp),
                        64'(want.meta.timestamp));
            check_value(p, "meta.pid", 64'(out_beat[p].meta.pid), 64'(want.meta.pid));
            check_value(p, "meta.trunc", 64'({out_beat[p].meta.trunc_enable,
                        out_beat[p].meta.trunc_length}),
                        64'({want.meta.trunc_enable, want.meta.trunc_length}));
        end
    endtask

    always @(posedge core_clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (rst_n && out_valid[p] && out_ready[p]) begin
                check_beat(p);
            end
        end
    end

    // ----------------------------------------
    // stimulus and expected beats
    // ----------------------------------------
    task automatic send_packet(input int p, input pkt_row_t r);
        stream_beat_t        beats [$];
        stream_beat_t        b;
        int                  nbeats;
        int                  out_len;
        int                  n;
        int                  waited;
        logic                en;
        logic                dropped;
        logic [LEN_BITS-1:0] tl;
        logic [PID_BITS-1:0] pid;
        nbeats = (r.len == '0) ? 1 : (int'(r.len) + 7) / 8;
        pid = PID_BITS'($urandom_range(1023));
        for (int k = 0; k < nbeats; k++) begin
            n = (int'(r.len) - 8 * k > 8) ? 8 : int'(r.len) - 8 * k;
            b = '0;
            b.data = {$urandom, $urandom};
            b.keep = keep_mask(n);
            b.last = (k == nbeats - 1);
            b.tid = port_t'(p);
            b.tdest = r.tdest;
            b.meta.pid = pid;
            b.meta.trunc_enable = r.m_en;
            b.meta.trunc_length = r.m_len;
            beats.push_back(b);
        end
        // configured truncation wins over the packet's own when overridden
        en = cfg.trunc_override ? cfg.trunc_enable : r.m_en;
        tl = cfg.trunc_override ? cfg.trunc_length : r.m_len;
        out_len = (en && int'(tl) < int'(r.len)) ? int'(tl) : int'(r.len);
        dropped = (r.len == '0) || (cfg.drop_loop && r.tdest == port_t'(p));
        for (int k = 0; k < nbeats; k++) begin
            @(negedge core_clk);
            in_beat[p]  = beats[k];
            in_valid[p] = 1'b1;
            waited = 0;
            @(posedge core_clk);
            while (!in_ready[p] && waited < WAIT_LIMIT) begin
                waited++;
                @(posedge core_clk);
            end
            if (!in_ready[p]) begin
                $display("port %0d input stalled for %0d cycles on beat %0d", p, waited, k);
                timed_out = 1'b1;
                return;
            end
            // timestamp is sampled when the first beat is taken
            if (k == 0 && !dropped) begin
                for (int j = 0; j * 8 < out_len; j++) begin
                    b = beats[j];
                    b.keep = keep_mask((out_len - 8 * j > 8) ? 8 : out_len - 8 * j);
                    b.last = ((j + 1) * 8 >= out_len);
                    b.meta.timestamp = timestamp;
                    b.meta.pid[PID_PORT_BIT] = 1'b0;
                    b.meta.trunc_enable = en;
                    b.meta.trunc_length = tl;
                    exp_q[p].push_back(b);
                end
            end
        end
    endtask

    task automatic send_port(input int p, input int ph);
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (int'(ROWS[i].phase) == ph && ROWS[i].port == port_t'(p) && !timed_out) begin
                send_packet(p, ROWS[i]);
            end
        end
        @(negedge core_clk);
        in_valid[p] = 1'b0;
    endtask

    // nothing may leave while pause is held for 50 cycles
    task automatic hold_pause();
        int leaks;
        leaks = 0;
        repeat (50) begin
            @(posedge core_clk);
            for (int p = 0; p < NUM_PORTS; p++) begin
                leaks += (out_valid[p] && out_ready[p]) ? 1 : 0;
            end
        end
        if (leaks != 0) begin
            $display("%0d beats left the DUT while the path was paused", leaks);
            errors++;
        end
        @(negedge core_clk);
        cfg.pause = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_q[0].size() != 0 || exp_q[1].size() != 0) && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge core_clk);
        end
        if (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            $display("expected beats still missing after %0d cycles", waited);
            timed_out = 1'b1;
        end
        repeat (10) @(posedge core_clk);
    endtask

    initial begin
        void'($urandom(39));
        core_clk  = 1'b0;
        rst_n     = 1'b0;
        cfg       = '0;
        timestamp = 48'h0000_1000_0000;
        errors    = 0;
        checked   = 0;
        timed_out = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_beat[p]   = '0;
            in_valid[p]  = 1'b0;
            out_ready[p] = 1'b0;
        end
        repeat (5) @(posedge core_clk);
        @(negedge core_clk);
        rst_n = 1'b1;
        for (int ph = 0; ph < 4 && !timed_out; ph++) begin
            @(negedge core_clk);
            cfg = PHASE_CFG[ph];
            fork
                send_port(0, ph);
                send_port(1, ph);
                if (PHASE_CFG[ph].pause) hold_pause();
            join
            if (!timed_out) wait_drain();
        end
        $display("checked %0d beats, %0d errors, %0d timeouts", checked, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
